//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       ?= tb_chdr_stream_endpoint
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SOURCES := $(wildcard src/*.sv test/*.sv test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sources.f
+incdir+test
src/chdr_ep_pkg.sv
src/chdr_ingress_demux.sv
src/chdr_mgmt_regs.sv
src/chdr_stream_framer.sv
src/chdr_egress_mux.sv
src/chdr_stream_endpoint.sv
test/tb_chdr_stream_endpoint.sv

//--- src/chdr_egress_mux.sv
// CHDR egress mux
// Merges management responses and framed data, whole packets only
`default_nettype none

module chdr_egress_mux #(
  parameter int CHDR_W = 64
) (
  input  wire                rfnoc_chdr_clk,
  input  wire                rfnoc_chdr_rst,
  input  wire [CHDR_W-1:0]   i_mresp_tdata,
  input  wire                i_mresp_tlast,
  input  wire                i_mresp_tvalid,
  output logic               o_mresp_tready,
  input  wire [CHDR_W-1:0]   i_fdat_tdata,
  input  wire                i_fdat_tlast,
  input  wire                i_fdat_tvalid,
  output logic               o_fdat_tready,
  output logic [CHDR_W-1:0]  o_chdr_tdata,
  output logic               o_chdr_tlast,
  output logic               o_chdr_tvalid,
  input  wire                i_chdr_tready
);

  logic locked;
  // 1 selects framed data, 0 management
  logic sel_r;
  logic sel_idle;
  logic sel;

  // Management first at idle
  assign sel_idle = !i_mresp_tvalid && i_fdat_tvalid;
  assign sel      = locked ? sel_r : sel_idle;

  assign o_chdr_tvalid  = sel ? i_fdat_tvalid : i_mresp_tvalid;
  assign o_chdr_tdata   = sel ? i_fdat_tdata  : i_mresp_tdata;
  assign o_chdr_tlast   = sel ? i_fdat_tlast  : i_mresp_tlast;
  assign o_mresp_tready = !sel && i_chdr_tready;
  assign o_fdat_tready  = sel && i_chdr_tready;

  // ------------------------------
  // Packet lock
  // ------------------------------
  // Lock as soon as a word is offered so the output never switches
  // source under back-pressure, release after the last word
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      locked <= 1'b0;
      sel_r  <= 1'b0;
    end else if (o_chdr_tvalid) begin
      if (i_chdr_tready && o_chdr_tlast) begin
        locked <= 1'b0;
      end else begin
        locked <= 1'b1;
        sel_r  <= sel;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/chdr_ep_pkg.sv
// CHDR stream endpoint shared definitions
// Packet types, header field positions, register map and FSM encodings
`default_nettype none

package chdr_ep_pkg;

  // CHDR packet type field
  typedef enum logic [2:0] {
    PKT_MGMT    = 3'd0,
    PKT_STRS    = 3'd1,
    PKT_STRC    = 3'd2,
    PKT_CTRL    = 3'd4,
    PKT_DATA    = 3'd6,
    PKT_DATA_TS = 3'd7
  } chdr_pkt_type_e;

  // ------------------------------
  // Header fields
  // ------------------------------
  localparam int HDR_TYPE_LSB = 53;
  localparam int HDR_SEQ_LSB  = 32;
  localparam int HDR_SRC_LSB  = 16;
  localparam int HDR_DST_LSB  = 0;
  localparam int EPID_W       = 16;
  localparam int SEQ_W        = 16;

  // ------------------------------
  // Management payload word
  // ------------------------------
  localparam int MGMT_WR_BIT   = 48;
  localparam int MGMT_ADDR_LSB = 32;
  localparam int REG_ADDR_W    = 16;
  localparam int REG_DATA_W    = 32;

  // Register map
  localparam logic [REG_ADDR_W-1:0] REG_EPID_SELF       = 16'h00;
  localparam logic [REG_ADDR_W-1:0] REG_RESET_AND_FLUSH = 16'h04;
  localparam logic [REG_ADDR_W-1:0] REG_OSTRM_DST_EPID  = 16'h0C;
  localparam logic [REG_ADDR_W-1:0] REG_ROUTE_ERR_CNT   = 16'h38;

  // Register file FSM
  typedef enum logic [1:0] {
    MGMT_HDR,
    MGMT_REQ,
    MGMT_RESP_HDR,
    MGMT_RESP_DATA
  } mgmt_state_e;

  // Ingress demux destinations
  typedef enum logic [1:0] {
    ROUTE_MGMT,
    ROUTE_DATA,
    ROUTE_DROP
  } demux_route_e;

endpackage

`default_nettype wire

//--- src/chdr_ingress_demux.sv
// CHDR ingress demux
// Sends management packets to the register file, strips data headers, drops the rest
`default_nettype none

module chdr_ingress_demux #(
  parameter int CHDR_W = 64
) (
  input  wire                            rfnoc_chdr_clk,
  input  wire                            rfnoc_chdr_rst,
  input  wire [CHDR_W-1:0]               i_chdr_tdata,
  input  wire                            i_chdr_tlast,
  input  wire                            i_chdr_tvalid,
  output logic                           o_chdr_tready,
  input  wire [chdr_ep_pkg::EPID_W-1:0]  i_epid_self,
  output logic [CHDR_W-1:0]              o_mreq_tdata,
  output logic                           o_mreq_tlast,
  output logic                           o_mreq_tvalid,
  input  wire                            i_mreq_tready,
  output logic [CHDR_W-1:0]              o_data_tdata,
  output logic                           o_data_tlast,
  output logic                           o_data_tvalid,
  input  wire                            i_data_tready,
  output logic                           o_route_err
);

  chdr_ep_pkg::chdr_pkt_type_e    hdr_type;
  chdr_ep_pkg::demux_route_e      hdr_route;
  chdr_ep_pkg::demux_route_e      route_r;
  chdr_ep_pkg::demux_route_e      cur_route;
  logic [chdr_ep_pkg::EPID_W-1:0] hdr_dst;
  logic                           in_pkt;
  logic                           accept;

  // ------------------------------
  // Header classification
  // ------------------------------
  assign hdr_type = chdr_ep_pkg::chdr_pkt_type_e'(
    i_chdr_tdata[chdr_ep_pkg::HDR_TYPE_LSB +: $bits(chdr_ep_pkg::chdr_pkt_type_e)]);
  assign hdr_dst  = i_chdr_tdata[chdr_ep_pkg::HDR_DST_LSB +: chdr_ep_pkg::EPID_W];

  always_comb begin
    case (hdr_type)
      chdr_ep_pkg::PKT_MGMT:
        hdr_route = chdr_ep_pkg::ROUTE_MGMT;
      chdr_ep_pkg::PKT_DATA, chdr_ep_pkg::PKT_DATA_TS:
        // Only data for this endpoint is accepted
        hdr_route = (hdr_dst == i_epid_self) ? chdr_ep_pkg::ROUTE_DATA
                                             : chdr_ep_pkg::ROUTE_DROP;
      default:
        hdr_route = chdr_ep_pkg::ROUTE_DROP;
    endcase
  end

  // Header word uses the fresh decision, body words the held one
  assign cur_route = in_pkt ? route_r : hdr_route;

  // ------------------------------
  // Path select
  // ------------------------------
  always_comb begin
    o_chdr_tready = 1'b1;
    o_mreq_tvalid = 1'b0;
    o_data_tvalid = 1'b0;
    case (cur_route)
      chdr_ep_pkg::ROUTE_MGMT: begin
        o_mreq_tvalid = i_chdr_tvalid;
        o_chdr_tready = i_mreq_tready;
      end
      chdr_ep_pkg::ROUTE_DATA: begin
        // Data header is consumed here and never reaches o_data
        o_data_tvalid = i_chdr_tvalid && in_pkt;
        o_chdr_tready = in_pkt ? i_data_tready : 1'b1;
      end
      default: begin
        // Drops sink one word per cycle
        o_chdr_tready = 1'b1;
      end
    endcase
  end

  assign o_mreq_tdata = i_chdr_tdata;
  assign o_mreq_tlast = i_chdr_tlast;
  assign o_data_tdata = i_chdr_tdata;
  assign o_data_tlast = i_chdr_tlast;

  assign accept = i_chdr_tvalid && o_chdr_tready;

  // Route hold and error strobe
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      in_pkt      <= 1'b0;
      route_r     <= chdr_ep_pkg::ROUTE_MGMT;
      o_route_err <= 1'b0;
    end else begin
      o_route_err <= accept && !in_pkt && (hdr_route == chdr_ep_pkg::ROUTE_DROP);
      if (accept) begin
        if (!in_pkt) begin
          route_r <= hdr_route;
        end
        in_pkt <= !i_chdr_tlast;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/chdr_mgmt_regs.sv
// Endpoint management register file
// Runs one read or write per two-word request and returns a response packet
`default_nettype none

module chdr_mgmt_regs #(
  parameter int CHDR_W = 64
) (
  input  wire                             rfnoc_chdr_clk,
  input  wire                             rfnoc_chdr_rst,
  input  wire [CHDR_W-1:0]                i_mreq_tdata,
  input  wire                             i_mreq_tlast,
  input  wire                             i_mreq_tvalid,
  output logic                            o_mreq_tready,
  output logic [CHDR_W-1:0]               o_mresp_tdata,
  output logic                            o_mresp_tlast,
  output logic                            o_mresp_tvalid,
  input  wire                             i_mresp_tready,
  input  wire                             i_route_err,
  output logic [chdr_ep_pkg::EPID_W-1:0]  o_epid_self,
  output logic [chdr_ep_pkg::EPID_W-1:0]  o_ostrm_dst_epid,
  output logic                            o_seq_restart
);

  chdr_ep_pkg::mgmt_state_e                state;
  logic [CHDR_W-1:0]                       req_hdr;
  logic                                    req_wr;
  logic [chdr_ep_pkg::REG_ADDR_W-1:0]      req_addr;
  logic [chdr_ep_pkg::REG_DATA_W-1:0]      wr_data;
  logic [chdr_ep_pkg::REG_DATA_W-1:0]      rd_val;
  logic [chdr_ep_pkg::REG_DATA_W-1:0]      resp_val;
  logic [chdr_ep_pkg::REG_DATA_W-1:0]      route_err_cnt;
  logic [CHDR_W-1:0]                       resp_word;
  logic                                    req_acc;
  logic                                    resp_acc;

  assign req_acc  = i_mreq_tvalid && o_mreq_tready;
  assign resp_acc = o_mresp_tvalid && i_mresp_tready;
  assign wr_data  = i_mreq_tdata[chdr_ep_pkg::REG_DATA_W-1:0];

  // Read mux on the captured address
  always_comb begin
    case (req_addr)
      chdr_ep_pkg::REG_EPID_SELF:      rd_val = {16'h0, o_epid_self};
      chdr_ep_pkg::REG_OSTRM_DST_EPID: rd_val = {16'h0, o_ostrm_dst_epid};
      chdr_ep_pkg::REG_ROUTE_ERR_CNT:  rd_val = route_err_cnt;
      default:                         rd_val = '0;
    endcase
  end

  // Response payload of flag, address and value
  always_comb begin
    resp_word = '0;
    resp_word[chdr_ep_pkg::MGMT_WR_BIT] = req_wr;
    resp_word[chdr_ep_pkg::MGMT_ADDR_LSB +: chdr_ep_pkg::REG_ADDR_W] = req_addr;
    resp_word[chdr_ep_pkg::REG_DATA_W-1:0] = resp_val;
  end

  assign o_mreq_tready  = (state == chdr_ep_pkg::MGMT_HDR) || (state == chdr_ep_pkg::MGMT_REQ);
  assign o_mresp_tvalid = (state == chdr_ep_pkg::MGMT_RESP_HDR) ||
                          (state == chdr_ep_pkg::MGMT_RESP_DATA);
  assign o_mresp_tlast  = (state == chdr_ep_pkg::MGMT_RESP_DATA);
  assign o_mresp_tdata  = (state == chdr_ep_pkg::MGMT_RESP_HDR) ? req_hdr : resp_word;

  // ------------------------------
  // Request and response FSM
  // ------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      state            <= chdr_ep_pkg::MGMT_HDR;
      req_wr           <= 1'b0;
      req_addr         <= '0;
      o_epid_self      <= '0;
      o_ostrm_dst_epid <= '0;
      o_seq_restart    <= 1'b0;
    end else begin
      o_seq_restart <= 1'b0;
      case (state)
        chdr_ep_pkg::MGMT_HDR: begin
          // A lone header word carries no request
          if (req_acc && !i_mreq_tlast) begin
            state <= chdr_ep_pkg::MGMT_REQ;
          end
        end
        chdr_ep_pkg::MGMT_REQ: begin
          if (req_acc) begin
            req_wr   <= i_mreq_tdata[chdr_ep_pkg::MGMT_WR_BIT];
            req_addr <= i_mreq_tdata[chdr_ep_pkg::MGMT_ADDR_LSB +: chdr_ep_pkg::REG_ADDR_W];
            // Writes land the next cycle
            if (i_mreq_tdata[chdr_ep_pkg::MGMT_WR_BIT]) begin
              case (i_mreq_tdata[chdr_ep_pkg::MGMT_ADDR_LSB +: chdr_ep_pkg::REG_ADDR_W])
                chdr_ep_pkg::REG_EPID_SELF:       o_epid_self      <= wr_data[15:0];
                chdr_ep_pkg::REG_OSTRM_DST_EPID:  o_ostrm_dst_epid <= wr_data[15:0];
                chdr_ep_pkg::REG_RESET_AND_FLUSH: o_seq_restart    <= wr_data[0];
                default: ;
              endcase
            end
            state <= chdr_ep_pkg::MGMT_RESP_HDR;
          end
        end
        chdr_ep_pkg::MGMT_RESP_HDR: begin
          if (resp_acc) begin
            state <= chdr_ep_pkg::MGMT_RESP_DATA;
          end
        end
        default: begin
          if (resp_acc) begin
            state <= chdr_ep_pkg::MGMT_HDR;
          end
        end
      endcase
    end
  end

  // Request header echoed back unchanged
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (req_acc && (state == chdr_ep_pkg::MGMT_HDR)) begin
      req_hdr <= i_mreq_tdata;
    end
    // Post-op value frozen while the payload word waits
    if (resp_acc && (state == chdr_ep_pkg::MGMT_RESP_HDR)) begin
      resp_val <= rd_val;
    end
  end

  // Dropped packet counter
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      route_err_cnt <= '0;
    end else if (i_route_err) begin
      route_err_cnt <= route_err_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/chdr_stream_endpoint.sv
// Reduced CHDR stream endpoint
// Ingress demux, management registers, stream framer and egress mux
`default_nettype none

module chdr_stream_endpoint #(
  parameter int CHDR_W = 64
) (
  input  wire                rfnoc_chdr_clk,
  input  wire                rfnoc_chdr_rst,
  // CHDR ingress
  input  wire [CHDR_W-1:0]   i_chdr_tdata,
  input  wire                i_chdr_tlast,
  input  wire                i_chdr_tvalid,
  output logic               o_chdr_tready,
  // CHDR egress
  output logic [CHDR_W-1:0]  o_chdr_tdata,
  output logic               o_chdr_tlast,
  output logic               o_chdr_tvalid,
  input  wire                i_chdr_tready,
  // Outgoing payload
  input  wire [CHDR_W-1:0]   i_data_tdata,
  input  wire                i_data_tlast,
  input  wire                i_data_tvalid,
  output logic               o_data_tready,
  // Received payload
  output logic [CHDR_W-1:0]  o_data_tdata,
  output logic               o_data_tlast,
  output logic               o_data_tvalid,
  input  wire                i_data_tready,
  output logic               o_route_err_stb
);

  // Management request and response
  logic [CHDR_W-1:0] mreq_tdata;
  logic              mreq_tlast;
  logic              mreq_tvalid;
  logic              mreq_tready;
  logic [CHDR_W-1:0] mresp_tdata;
  logic              mresp_tlast;
  logic              mresp_tvalid;
  logic              mresp_tready;
  // Framed outgoing data
  logic [CHDR_W-1:0] fdat_tdata;
  logic              fdat_tlast;
  logic              fdat_tvalid;
  logic              fdat_tready;
  // Configuration
  logic [chdr_ep_pkg::EPID_W-1:0] epid_self;
  logic [chdr_ep_pkg::EPID_W-1:0] ostrm_dst_epid;
  logic                           seq_restart;

  // ------------------------------
  // Input side
  // ------------------------------
  chdr_ingress_demux #(.CHDR_W(CHDR_W)) u_demux (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .i_chdr_tdata   (i_chdr_tdata),
    .i_chdr_tlast   (i_chdr_tlast),
    .i_chdr_tvalid  (i_chdr_tvalid),
    .o_chdr_tready  (o_chdr_tready),
    .i_epid_self    (epid_self),
    .o_mreq_tdata   (mreq_tdata),
    .o_mreq_tlast   (mreq_tlast),
    .o_mreq_tvalid  (mreq_tvalid),
    .i_mreq_tready  (mreq_tready),
    .o_data_tdata   (o_data_tdata),
    .o_data_tlast   (o_data_tlast),
    .o_data_tvalid  (o_data_tvalid),
    .i_data_tready  (i_data_tready),
    .o_route_err    (o_route_err_stb)
  );

  // ------------------------------
  // Processing
  // ------------------------------
  chdr_mgmt_regs #(.CHDR_W(CHDR_W)) u_regs (
    .rfnoc_chdr_clk   (rfnoc_chdr_clk),
    .rfnoc_chdr_rst   (rfnoc_chdr_rst),
    .i_mreq_tdata     (mreq_tdata),
    .i_mreq_tlast     (mreq_tlast),
    .i_mreq_tvalid    (mreq_tvalid),
    .o_mreq_tready    (mreq_tready),
    .o_mresp_tdata    (mresp_tdata),
    .o_mresp_tlast    (mresp_tlast),
    .o_mresp_tvalid   (mresp_tvalid),
    .i_mresp_tready   (mresp_tready),
    .i_route_err      (o_route_err_stb),
    .o_epid_self      (epid_self),
    .o_ostrm_dst_epid (ostrm_dst_epid),
    .o_seq_restart    (seq_restart)
  );

  chdr_stream_framer #(.CHDR_W(CHDR_W)) u_framer (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .i_data_tdata   (i_data_tdata),
    .i_data_tlast   (i_data_tlast),
    .i_data_tvalid  (i_data_tvalid),
    .o_data_tready  (o_data_tready),
    .o_fdat_tdata   (fdat_tdata),
    .o_fdat_tlast   (fdat_tlast),
    .o_fdat_tvalid  (fdat_tvalid),
    .i_fdat_tready  (fdat_tready),
    .i_epid_self    (epid_self),
    .i_dst_epid     (ostrm_dst_epid),
    .i_seq_restart  (seq_restart)
  );

  // Output side
  chdr_egress_mux #(.CHDR_W(CHDR_W)) u_mux (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .i_mresp_tdata  (mresp_tdata),
    .i_mresp_tlast  (mresp_tlast),
    .i_mresp_tvalid (mresp_tvalid),
    .o_mresp_tready (mresp_tready),
    .i_fdat_tdata   (fdat_tdata),
    .i_fdat_tlast   (fdat_tlast),
    .i_fdat_tvalid  (fdat_tvalid),
    .o_fdat_tready  (fdat_tready),
    .o_chdr_tdata   (o_chdr_tdata),
    .o_chdr_tlast   (o_chdr_tlast),
    .o_chdr_tvalid  (o_chdr_tvalid),
    .i_chdr_tready  (i_chdr_tready)
  );

endmodule

`default_nettype wire

//--- src/chdr_stream_framer.sv
// Outgoing stream framer
// Puts a CHDR data header with endpoint IDs and sequence number before each packet
`default_nettype none

module chdr_stream_framer #(
  parameter int CHDR_W = 64
) (
  input  wire                            rfnoc_chdr_clk,
  input  wire                            rfnoc_chdr_rst,
  input  wire [CHDR_W-1:0]               i_data_tdata,
  input  wire                            i_data_tlast,
  input  wire                            i_data_tvalid,
  output logic                           o_data_tready,
  output logic [CHDR_W-1:0]              o_fdat_tdata,
  output logic                           o_fdat_tlast,
  output logic                           o_fdat_tvalid,
  input  wire                            i_fdat_tready,
  input  wire [chdr_ep_pkg::EPID_W-1:0]  i_epid_self,
  input  wire [chdr_ep_pkg::EPID_W-1:0]  i_dst_epid,
  input  wire                            i_seq_restart
);

  // Set once the header of the current packet has gone out
  logic                          hdr_sent;
  logic [chdr_ep_pkg::SEQ_W-1:0] seq_num;
  logic [CHDR_W-1:0]             hdr_word;

  // Plain data header, all unused fields zero
  always_comb begin
    hdr_word = '0;
    hdr_word[chdr_ep_pkg::HDR_TYPE_LSB +: $bits(chdr_ep_pkg::chdr_pkt_type_e)] =
      chdr_ep_pkg::PKT_DATA;
    hdr_word[chdr_ep_pkg::HDR_SEQ_LSB +: chdr_ep_pkg::SEQ_W]  = seq_num;
    hdr_word[chdr_ep_pkg::HDR_SRC_LSB +: chdr_ep_pkg::EPID_W] = i_epid_self;
    hdr_word[chdr_ep_pkg::HDR_DST_LSB +: chdr_ep_pkg::EPID_W] = i_dst_epid;
  end

  // Header slot stalls the payload, then straight through
  assign o_fdat_tvalid = i_data_tvalid;
  assign o_fdat_tdata  = hdr_sent ? i_data_tdata : hdr_word;
  assign o_fdat_tlast  = hdr_sent && i_data_tlast;
  assign o_data_tready = hdr_sent && i_fdat_tready;

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      hdr_sent <= 1'b0;
      seq_num  <= '0;
    end else begin
      if (o_fdat_tvalid && i_fdat_tready) begin
        if (!hdr_sent) begin
          hdr_sent <= 1'b1;
        end else if (i_data_tlast) begin
          hdr_sent <= 1'b0;
        end
      end
      // Restart wins over a packet ending the same cycle
      if (i_seq_restart) begin
        seq_num <= '0;
      end else if (hdr_sent && i_data_tvalid && i_fdat_tready && i_data_tlast) begin
        seq_num <= seq_num + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_chdr_model.svh
// Reference model for the CHDR stream endpoint testbench
// Expected registers, expected output queues and packet builders
`ifndef TB_CHDR_MODEL_SVH
`define TB_CHDR_MODEL_SVH

  // Expected register state
  logic [15:0] m_epid_self;
  logic [15:0] m_dst_epid;
  logic [15:0] m_seq;
  int          m_drops;

  // Expected output words, bit 64 is tlast
  logic [64:0] exp_mgmt_q[$];
  logic [64:0] exp_fdat_q[$];
  logic [64:0] exp_data_q[$];

  // Words waiting to go into the DUT
  logic [63:0] chdr_tx_q[$];
  logic [63:0] data_tx_q[$];

  task automatic model_reset();
    m_epid_self = 16'h0;
    m_dst_epid  = 16'h0;
    m_seq       = 16'h0;
    m_drops     = 0;
    exp_mgmt_q.delete();
    exp_fdat_q.delete();
    exp_data_q.delete();
  endtask

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand32();
    lo = rand32();
    return {hi, lo};
  endfunction

  // Payload length of 1 to 8 words
  function automatic int rand_len();
    logic [31:0] r;
    r = rand32();
    return int'(r[2:0]) + 1;
  endfunction

  // ------------------------------
  // Packet builders
  // ------------------------------
  // Type at 53, sequence at 32, source at 16, destination at 0
  function automatic logic [63:0] make_hdr(input logic [2:0] pkt_type, input logic [15:0] seq,
                                           input logic [15:0] src, input logic [15:0] dst);
    logic [63:0] hdr;
    hdr        = 64'h0;
    hdr[55:53] = pkt_type;
    hdr[47:32] = seq;
    hdr[31:16] = src;
    hdr[15:0]  = dst;
    return hdr;
  endfunction

  // One register request, expected response is the echoed header plus the post-op value
  task automatic build_mgmt(input logic wr, input logic [15:0] addr, input logic [31:0] data);
    logic [63:0] hdr;
    logic [31:0] value;
    logic [31:0] r;
    r   = rand32();
    hdr = make_hdr(3'd0, r[15:0], r[31:16], m_epid_self);
    if (wr) begin
      case (addr)
        16'h00: m_epid_self = data[15:0];
        16'h0C: m_dst_epid  = data[15:0];
        16'h04: begin
          // Bit 0 restarts the outgoing sequence
          if (data[0]) begin
            m_seq = 16'h0;
          end
        end
        default: ;
      endcase
    end
    case (addr)
      16'h00:  value = {16'h0, m_epid_self};
      16'h0C:  value = {16'h0, m_dst_epid};
      16'h38:  value = 32'(m_drops);
      default: value = 32'h0;
    endcase
    chdr_tx_q.delete();
    chdr_tx_q.push_back(hdr);
    chdr_tx_q.push_back({15'h0, wr, addr, data});
    exp_mgmt_q.push_back({1'b0, hdr});
    exp_mgmt_q.push_back({1'b1, 15'h0, wr, addr, value});
  endtask

  // Incoming packet, kept only if data for this endpoint
  task automatic build_data_in(input logic [2:0] pkt_type, input logic [15:0] dst, input int len);
    logic [63:0] word;
    logic [31:0] r;
    logic        keep;
    r    = rand32();
    keep = ((pkt_type == 3'd6) || (pkt_type == 3'd7)) && (dst == m_epid_self);
    chdr_tx_q.delete();
    chdr_tx_q.push_back(make_hdr(pkt_type, r[15:0], r[31:16], dst));
    for (int i = 0; i < len; i++) begin
      word = rand64();
      chdr_tx_q.push_back(word);
      if (keep) begin
        exp_data_q.push_back({(i == len - 1), word});
      end
    end
    if (!keep) begin
      m_drops++;
    end
  endtask

  // Outgoing payload, expected on o_chdr behind a fresh data header
  task automatic build_data_out(input int len);
    logic [63:0] word;
    data_tx_q.delete();
    exp_fdat_q.push_back({1'b0, make_hdr(3'd6, m_seq, m_epid_self, m_dst_epid)});
    for (int i = 0; i < len; i++) begin
      word = rand64();
      data_tx_q.push_back(word);
      exp_fdat_q.push_back({(i == len - 1), word});
    end
    m_seq = m_seq + 16'd1;
  endtask

`endif

//--- test/tb_chdr_stream_endpoint.sv
// Testbench for the reduced CHDR stream endpoint
// Random packets on all inputs, checked against the model in tb_chdr_model
`default_nettype none

module tb_chdr_stream_endpoint;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CHDR_W  = 64;
  localparam int CLK_NS  = 4;
  // Upper bound on packets sent, longest packet is header plus 8 words
  localparam int N_PKTS  = 100;
  localparam int MAX_LEN = 9;

  logic              rfnoc_chdr_clk = 1'b0;
  logic              rfnoc_chdr_rst;
  logic [CHDR_W-1:0] i_chdr_tdata;
  logic              i_chdr_tlast;
  logic              i_chdr_tvalid;
  logic              o_chdr_tready;
  logic [CHDR_W-1:0] o_chdr_tdata;
  logic              o_chdr_tlast;
  logic              o_chdr_tvalid;
  logic              i_chdr_tready = 1'b0;
  logic [CHDR_W-1:0] i_data_tdata;
  logic              i_data_tlast;
  logic              i_data_tvalid;
  logic              o_data_tready;
  logic [CHDR_W-1:0] o_data_tdata;
  logic              o_data_tlast;
  logic              o_data_tvalid;
  logic              i_data_tready = 1'b0;
  logic              o_route_err_stb;

  integer seed = 29779;
  int     n_checks = 0;
  int     n_errors = 0;
  int     chk_base = 0;
  int     err_base = 0;
  int     err_pulses = 0;
  logic   mon_in_pkt = 1'b0;
  logic   mon_mgmt = 1'b0;

  `include "tb_chdr_model.svh"

  chdr_stream_endpoint #(.CHDR_W(CHDR_W)) i_dut (
    .rfnoc_chdr_clk  (rfnoc_chdr_clk),
    .rfnoc_chdr_rst  (rfnoc_chdr_rst),
    .i_chdr_tdata    (i_chdr_tdata),
    .i_chdr_tlast    (i_chdr_tlast),
    .i_chdr_tvalid   (i_chdr_tvalid),
    .o_chdr_tready   (o_chdr_tready),
    .o_chdr_tdata    (o_chdr_tdata),
    .o_chdr_tlast    (o_chdr_tlast),
    .o_chdr_tvalid   (o_chdr_tvalid),
    .i_chdr_tready   (i_chdr_tready),
    .i_data_tdata    (i_data_tdata),
    .i_data_tlast    (i_data_tlast),
    .i_data_tvalid   (i_data_tvalid),
    .o_data_tready   (o_data_tready),
    .o_data_tdata    (o_data_tdata),
    .o_data_tlast    (o_data_tlast),
    .o_data_tvalid   (o_data_tvalid),
    .i_data_tready   (i_data_tready),
    .o_route_err_stb (o_route_err_stb)
  );

  always #(CLK_NS / 2) rfnoc_chdr_clk = ~rfnoc_chdr_clk;

  // Random back-pressure on both outputs, ready about 3 cycles in 4
  always @(posedge rfnoc_chdr_clk) begin
    logic [31:0] r;
    #1;
    r = rand32();
    i_chdr_tready = (r[1:0] != 2'b00);
    i_data_tready = (r[3:2] != 2'b00);
  end

  task automatic check_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // ------------------------------
  // Output monitors
  // ------------------------------
  // Header type picks the expected source, the rest of the packet must follow it
  always @(negedge rfnoc_chdr_clk) begin
    logic [64:0] exp_word;
    if (!rfnoc_chdr_rst && o_chdr_tvalid && i_chdr_tready) begin
      if (!mon_in_pkt) begin
        mon_mgmt = (o_chdr_tdata[55:53] == 3'd0);
      end
      if (mon_mgmt ? (exp_mgmt_q.size() == 0) : (exp_fdat_q.size() == 0)) begin
        $display("Unexpected word on o_chdr at %0t ns", $time);
        n_errors++;
      end else begin
        exp_word = mon_mgmt ? exp_mgmt_q.pop_front() : exp_fdat_q.pop_front();
        check_equal("o_chdr_tdata", o_chdr_tdata, exp_word[63:0]);
        check_equal("o_chdr_tlast", 64'(o_chdr_tlast), 64'(exp_word[64]));
      end
      mon_in_pkt = !o_chdr_tlast;
    end
  end

  always @(negedge rfnoc_chdr_clk) begin
    logic [64:0] exp_word;
    if (!rfnoc_chdr_rst && o_data_tvalid && i_data_tready) begin
      if (exp_data_q.size() == 0) begin
        $display("Unexpected word on o_data at %0t ns", $time);
        n_errors++;
      end else begin
        exp_word = exp_data_q.pop_front();
        check_equal("o_data_tdata", o_data_tdata, exp_word[63:0]);
        check_equal("o_data_tlast", 64'(o_data_tlast), 64'(exp_word[64]));
      end
    end
  end

  always @(negedge rfnoc_chdr_clk) begin
    if (!rfnoc_chdr_rst && o_route_err_stb) begin
      err_pulses++;
    end
  end

  // ------------------------------
  // Drivers, entered 1 ns after a rising edge
  // ------------------------------
  task automatic drive_chdr();
    for (int i = 0; i < chdr_tx_q.size(); i++) begin
      i_chdr_tdata  = chdr_tx_q[i];
      i_chdr_tlast  = (i == chdr_tx_q.size() - 1);
      i_chdr_tvalid = 1'b1;
      do begin
        @(negedge rfnoc_chdr_clk);
      end while (!o_chdr_tready);
      @(posedge rfnoc_chdr_clk);
      #1;
    end
    i_chdr_tvalid = 1'b0;
    i_chdr_tlast  = 1'b0;
  endtask

  task automatic drive_data();
    for (int i = 0; i < data_tx_q.size(); i++) begin
      i_data_tdata  = data_tx_q[i];
      i_data_tlast  = (i == data_tx_q.size() - 1);
      i_data_tvalid = 1'b1;
      do begin
        @(negedge rfnoc_chdr_clk);
      end while (!o_data_tready);
      @(posedge rfnoc_chdr_clk);
      #1;
    end
    i_data_tvalid = 1'b0;
    i_data_tlast  = 1'b0;
  endtask

  task automatic send_mgmt(input logic wr, input logic [15:0] addr, input logic [31:0] data);
    build_mgmt(wr, addr, data);
    drive_chdr();
  endtask

  task automatic send_data_out(input int len);
    build_data_out(len);
    drive_data();
  endtask

  // Reads of the live registers mixed with writes to an unmapped address
  task automatic send_mgmt_mix(input int n);
    logic [31:0] r;
    repeat (n) begin
      r = rand32();
      case (r[1:0])
        2'd0:    send_mgmt(1'b0, 16'h00, r);
        2'd1:    send_mgmt(1'b0, 16'h0C, r);
        2'd2:    send_mgmt(1'b0, 16'h38, r);
        default: send_mgmt(1'b1, 16'h0100, r);
      endcase
    end
  endtask

  // Until every expected word has come out
  task automatic wait_drain();
    do begin
      @(posedge rfnoc_chdr_clk);
    end while (exp_mgmt_q.size() + exp_fdat_q.size() + exp_data_q.size() != 0);
    #1;
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d checks, %0d errors", name, n_checks - chk_base, n_errors - err_base);
    chk_base = n_checks;
    err_base = n_errors;
  endtask

  initial begin
    logic [31:0] r;
    i_chdr_tdata   = '0;
    i_chdr_tlast   = 1'b0;
    i_chdr_tvalid  = 1'b0;
    i_data_tdata   = '0;
    i_data_tlast   = 1'b0;
    i_data_tvalid  = 1'b0;
    rfnoc_chdr_rst = 1'b1;
    model_reset();
    repeat (10) @(posedge rfnoc_chdr_clk);
    #1;
    rfnoc_chdr_rst = 1'b0;

    // Register writes and reads, unmapped address reads 0
    send_mgmt(1'b1, 16'h00, rand32());
    send_mgmt(1'b1, 16'h0C, rand32());
    send_mgmt(1'b0, 16'h00, rand32());
    send_mgmt(1'b0, 16'h0C, rand32());
    send_mgmt(1'b1, 16'h0100, rand32());
    send_mgmt(1'b0, 16'h0100, rand32());
    wait_drain();
    end_test("register access");

    repeat (20) begin
      r = rand32();
      build_data_in(r[0] ? 3'd7 : 3'd6, m_epid_self, rand_len());
      drive_chdr();
    end
    wait_drain();
    end_test("stream input");

    // Other types and data for another endpoint
    repeat (20) begin
      r = rand32();
      case (r[1:0])
        2'd0:    build_data_in(3'd1, m_epid_self, rand_len());
        2'd1:    build_data_in(3'd2, m_epid_self, rand_len());
        2'd2:    build_data_in(3'd4, m_epid_self, rand_len());
        default: build_data_in(r[2] ? 3'd7 : 3'd6, m_epid_self ^ (r[31:16] | 16'h1), rand_len());
      endcase
      drive_chdr();
    end
    wait_drain();
    check_equal("o_route_err_stb count", 64'(err_pulses), 64'(m_drops));
    send_mgmt(1'b0, 16'h38, rand32());
    wait_drain();
    end_test("drops");

    repeat (20) begin
      send_data_out(rand_len());
    end
    wait_drain();
    end_test("stream output");

    send_mgmt(1'b1, 16'h04, 32'h1);
    wait_drain();
    repeat (3) begin
      send_data_out(rand_len());
    end
    wait_drain();
    end_test("sequence restart");

    // Both egress sources busy at once
    fork
      send_mgmt_mix(8);
      begin
        repeat (10) begin
          send_data_out(rand_len());
        end
      end
    join
    wait_drain();
    end_test("whole packets");

    $display("total: %0d checks, %0d errors, %0d route errors", n_checks, n_errors, err_pulses);
    if (n_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog sized from packet count and length
  initial begin
    #(N_PKTS * MAX_LEN * 20 * CLK_NS);
    $display("Watchdog timeout, the DUT stopped moving packets");
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire
